/* Bender.yml */
package:
  name: dma_cpci

sources:
  - files:
      - source/dma_pkg.sv
      - source/sync_fifo.sv
      - source/dma_bus_fsm.sv
      - source/dma_cpci_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/dma_cpci_tb.sv

/* dma_cpci.f */
+incdir+include
source/dma_pkg.sv
source/sync_fifo.sv
source/dma_bus_fsm.sv
source/dma_cpci_top.sv
tb/dma_cpci_tb.sv

/* source/dma_bus_fsm.sv */
`timescale 1ns/1ps
//////////////////////////////
// cpci dma bus state machine
//////////////////////////////
module dma_bus_fsm (
	// cpci pins
	input  logic [1:0]                         dma_op_code_req,
	input  logic [3:0]                         dma_op_queue_id,
	output logic [1:0]                         dma_op_code_ack,
	input  logic                               dma_vld_c2n,
	input  logic [dma_pkg::DMA_DATA_WIDTH-1:0] dma_data_c2n,
	output logic                               dma_dest_q_nearly_full_n2c,
	output logic                               dma_vld_n2c,
	output logic [dma_pkg::DMA_DATA_WIDTH-1:0] dma_data_n2c,
	input  logic                               dma_dest_q_nearly_full_c2n,
	output logic                               dma_data_tri_en,
	// core status levels
	input  logic [dma_pkg::NUM_CPU_QUEUES-1:0] cpu_q_dma_pkt_avail,
	input  logic [dma_pkg::NUM_CPU_QUEUES-1:0] cpu_q_dma_nearly_full,
	// transmit queue, write side
	input  logic                               txfifo_nearly_full,
	output logic                               txfifo_wr,
	output dma_pkg::txq_word_t                 txfifo_wr_data,
	// receive queue, show-ahead read side
	input  logic                               rxfifo_empty,
	input  logic [dma_pkg::RXQ_WIDTH-1:0]      rxfifo_rd_data,
	output logic                               rxfifo_rd_inc,
	input  logic                               enable_dma,
	input  logic                               cpci_clk,
	input  logic                               cpci_reset
);
	import dma_pkg::*;

	// registered pin inputs
	logic [1:0]                op_code_req_d;
	logic [3:0]                op_queue_id_d;
	logic                      vld_c2n_d;
	logic [DMA_DATA_WIDTH-1:0] data_c2n_d;
	logic                      nearly_full_c2n_d;

	logic [3:0]                   state, state_nxt;
	logic [1:0]                   op_code_ack_nxt;
	logic                         vld_n2c_nxt;
	logic [DMA_DATA_WIDTH-1:0]    data_n2c_nxt;
	logic                         tri_en_nxt;
	logic [PKT_LEN_CNT_WIDTH-1:0] tx_pkt_len, tx_pkt_len_nxt;
	logic [PKT_LEN_CNT_WIDTH-1:0] rx_pkt_len, rx_pkt_len_nxt;
	logic [PKT_LEN_CNT_WIDTH-1:0] rx_pkt_len_sum;
	logic [2:0]                   rx_word_bytes;
	logic                         tx_last_word, rx_last_word;

	logic                      pkt_buf_srst, pkt_buf_wr_en;
	logic                      pkt_buf_rd_en, pkt_buf_rd_en_d;
	logic                      pkt_buf_empty;
	logic [DMA_DATA_WIDTH-1:0] pkt_buf_rd_data;

	always_ff @(posedge cpci_clk) begin
		op_code_req_d     <= dma_op_code_req;
		op_queue_id_d     <= dma_op_queue_id;
		vld_c2n_d         <= dma_vld_c2n;
		data_c2n_d        <= dma_data_c2n;
		nearly_full_c2n_d <= dma_dest_q_nearly_full_c2n;
	end

	assign tx_last_word   = (tx_pkt_len <= 4);
	assign rx_last_word   = (rx_pkt_len <= 4);
	assign rx_word_bytes  = (rxfifo_rd_data[RXQ_BCNT_LSB +: 2] == 2'd0) ? 3'd4 :
		{1'b0, rxfifo_rd_data[RXQ_BCNT_LSB +: 2]};
	assign rx_pkt_len_sum = rx_pkt_len + PKT_LEN_CNT_WIDTH'(rx_word_bytes);

	//////////////////////////////
	// next state logic
	//////////////////////////////
	always_comb begin
		state_nxt       = state;
		op_code_ack_nxt = dma_op_code_ack;
		vld_n2c_nxt     = 1'b0;  // strobe
		data_n2c_nxt    = '0;
		tri_en_nxt      = dma_data_tri_en;
		tx_pkt_len_nxt  = tx_pkt_len;
		rx_pkt_len_nxt  = rx_pkt_len;
		txfifo_wr       = 1'b0;
		txfifo_wr_data  = '0;
		rxfifo_rd_inc   = 1'b0;
		pkt_buf_srst    = 1'b0;
		pkt_buf_wr_en   = 1'b0;
		pkt_buf_rd_en   = 1'b0;

		case (state)
			S_IDLE: begin
				if (enable_dma) begin
					case (op_code_req_d)
						OP_CODE_STATUS_QUERY: state_nxt = S_QUERY;
						OP_CODE_TRANSF_C2N:   state_nxt = S_C2N_QID;
						OP_CODE_TRANSF_N2C:   state_nxt = S_N2C_QID;
						default:              state_nxt = S_IDLE;
					endcase
				end
			end

			S_QUERY: begin
				op_code_ack_nxt = OP_CODE_STATUS_QUERY;
				tri_en_nxt      = 1'b1;
				vld_n2c_nxt     = (dma_op_code_ack != OP_CODE_STATUS_QUERY); // first cycle only
				data_n2c_nxt    = {{(16-NUM_CPU_QUEUES){1'b0}}, cpu_q_dma_pkt_avail,
					{(16-NUM_CPU_QUEUES){1'b0}}, cpu_q_dma_nearly_full};
				if (op_code_req_d == OP_CODE_TRANSF_C2N)
					state_nxt = S_C2N_QID;
				else if (op_code_req_d == OP_CODE_TRANSF_N2C)
					state_nxt = S_N2C_QID;
			end

			S_C2N_QID: begin
				op_code_ack_nxt                  = OP_CODE_TRANSF_C2N;
				tri_en_nxt                       = 1'b0;
				txfifo_wr                        = 1'b1;
				txfifo_wr_data.req_view.is_req   = 1'b1;
				txfifo_wr_data.req_view.queue_id = op_queue_id_d;
				state_nxt                        = S_C2N_LEN;
			end

			// length word goes into the queue as plain data
			S_C2N_LEN: begin
				if (vld_c2n_d) begin
					tx_pkt_len_nxt               = data_c2n_d[PKT_LEN_CNT_WIDTH-1:0];
					txfifo_wr                    = 1'b1;
					txfifo_wr_data.data_view.data = data_c2n_d;
					if (tx_pkt_len_nxt == '0) begin
						txfifo_wr_data.data_view.eop = 1'b1; // empty packet
						state_nxt                    = S_C2N_DONE;
					end else begin
						state_nxt = S_C2N_DATA;
					end
				end
			end

			S_C2N_DATA: begin
				if (vld_c2n_d) begin
					txfifo_wr                     = 1'b1;
					txfifo_wr_data.data_view.data = data_c2n_d;
					if (tx_last_word) begin
						txfifo_wr_data.data_view.eop         = 1'b1;
						txfifo_wr_data.data_view.valid_bytes = tx_pkt_len[1:0];
						tx_pkt_len_nxt                       = '0;
						state_nxt                            = S_C2N_DONE;
					end else begin
						tx_pkt_len_nxt = tx_pkt_len - 4'd4;
					end
				end
			end

			S_C2N_DONE: begin
				if (op_code_req_d == OP_CODE_STATUS_QUERY)
					state_nxt = S_QUERY;
				else if (op_code_req_d == OP_CODE_TRANSF_N2C)
					state_nxt = S_N2C_QID;
			end

			S_N2C_QID: begin
				op_code_ack_nxt                  = OP_CODE_TRANSF_N2C;
				tri_en_nxt                       = 1'b1;
				txfifo_wr                        = 1'b1;
				txfifo_wr_data.req_view.is_req   = 1'b1;
				txfifo_wr_data.req_view.dir_rx   = 1'b1;
				txfifo_wr_data.req_view.queue_id = op_queue_id_d;
				rx_pkt_len_nxt                   = '0;
				pkt_buf_srst                     = 1'b1; // drop leftovers of last packet
				state_nxt                        = S_N2C_ENQ;
			end

			// collect the whole packet before the length is known
			S_N2C_ENQ: begin
				if (!rxfifo_empty) begin
					rxfifo_rd_inc  = 1'b1;
					pkt_buf_wr_en  = 1'b1;
					rx_pkt_len_nxt = rx_pkt_len_sum;
					if ((rx_pkt_len_sum > PKT_LEN_THRESHOLD) || rxfifo_rd_data[RXQ_EOP_BIT])
						state_nxt = S_N2C_LEN;
				end
			end

			S_N2C_LEN: begin
				if (!nearly_full_c2n_d) begin
					vld_n2c_nxt  = 1'b1;
					data_n2c_nxt = {{(DMA_DATA_WIDTH-PKT_LEN_CNT_WIDTH){1'b0}}, rx_pkt_len};
					state_nxt    = S_N2C_DEQ;
				end
			end

			S_N2C_DEQ: begin
				pkt_buf_rd_en = !nearly_full_c2n_d && !pkt_buf_empty;
				if (pkt_buf_rd_en_d) begin // word read last cycle is on dout
					vld_n2c_nxt  = 1'b1;
					data_n2c_nxt = pkt_buf_rd_data;
					if (rx_last_word) begin
						rx_pkt_len_nxt = '0;
						state_nxt      = S_N2C_DONE;
					end else begin
						rx_pkt_len_nxt = rx_pkt_len - 4'd4;
					end
				end
			end

			S_N2C_DONE: begin
				if (op_code_req_d == OP_CODE_STATUS_QUERY)
					state_nxt = S_QUERY;
				else if (op_code_req_d == OP_CODE_TRANSF_C2N)
					state_nxt = S_C2N_QID;
			end

			default: state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge cpci_clk) begin
		if (cpci_reset) begin
			state                      <= S_IDLE;
			dma_op_code_ack            <= OP_CODE_IDLE;
			dma_vld_n2c                <= 1'b0;
			dma_data_tri_en            <= 1'b0;
			dma_dest_q_nearly_full_n2c <= 1'b0;
			tx_pkt_len                 <= '0;
			rx_pkt_len                 <= '0;
			pkt_buf_rd_en_d            <= 1'b0;
		end else begin
			state                      <= state_nxt;
			dma_op_code_ack            <= op_code_ack_nxt;
			dma_vld_n2c                <= vld_n2c_nxt;
			dma_data_tri_en            <= tri_en_nxt;
			dma_dest_q_nearly_full_n2c <= txfifo_nearly_full;
			tx_pkt_len                 <= tx_pkt_len_nxt;
			rx_pkt_len                 <= rx_pkt_len_nxt;
			pkt_buf_rd_en_d            <= pkt_buf_rd_en;
		end
	end

	always_ff @(posedge cpci_clk) begin
		dma_data_n2c <= data_n2c_nxt;
	end

	// n2c packet buffer, standard read
	sync_fifo #(
		.WIDTH      (DMA_DATA_WIDTH),
		.DEPTH_LOG2 (PKT_BUF_DEPTH_LOG2),
		.SHOW_AHEAD (1'b0)
	) pkt_buf (
		.cpci_clk    (cpci_clk),
		.cpci_reset  (cpci_reset),
		.srst        (pkt_buf_srst),
		.wr_en       (pkt_buf_wr_en),
		.din         (rxfifo_rd_data[DMA_DATA_WIDTH-1:0]),
		.rd_en       (pkt_buf_rd_en),
		.dout        (pkt_buf_rd_data),
		.empty       (pkt_buf_empty),
		.full        (),
		.nearly_full ()
	);

endmodule

/* source/dma_cpci_top.sv */
`timescale 1ns/1ps
//////////////////////////////
// cpci dma engine top
//////////////////////////////
module dma_cpci_top (
	// cpci pins
	input  logic [1:0]                         dma_op_code_req,
	input  logic [3:0]                         dma_op_queue_id,
	output logic [1:0]                         dma_op_code_ack,
	input  logic                               dma_vld_c2n,
	input  logic [dma_pkg::DMA_DATA_WIDTH-1:0] dma_data_c2n,
	output logic                               dma_dest_q_nearly_full_n2c,
	output logic                               dma_vld_n2c,
	output logic [dma_pkg::DMA_DATA_WIDTH-1:0] dma_data_n2c,
	input  logic                               dma_dest_q_nearly_full_c2n,
	output logic                               dma_data_tri_en,
	// core status levels
	input  logic [dma_pkg::NUM_CPU_QUEUES-1:0] cpu_q_dma_pkt_avail,
	input  logic [dma_pkg::NUM_CPU_QUEUES-1:0] cpu_q_dma_nearly_full,
	input  logic                               enable_dma,
	// core side of the queues
	input  logic                               txq_rd_en,
	output dma_pkg::txq_word_t                 txq_rd_data,
	output logic                               txq_empty,
	input  logic                               rxq_wr_en,
	input  logic [dma_pkg::RXQ_WIDTH-1:0]      rxq_wr_data,
	output logic                               rxq_full,
	input  logic                               cpci_clk,
	input  logic                               cpci_reset
);
	import dma_pkg::*;

	logic                 txfifo_wr;
	txq_word_t            txfifo_wr_data;
	logic                 txfifo_nearly_full;
	logic                 rxfifo_empty;
	logic [RXQ_WIDTH-1:0] rxfifo_rd_data;
	logic                 rxfifo_rd_inc;

	dma_bus_fsm u_bus_fsm (.*);

	// host to card, core reads with standard timing
	sync_fifo #(
		.WIDTH      ($bits(txq_word_t)),
		.DEPTH_LOG2 (TXQ_DEPTH_LOG2),
		.SHOW_AHEAD (1'b0)
	) tx_queue (
		.cpci_clk    (cpci_clk),
		.cpci_reset  (cpci_reset),
		.srst        (1'b0),
		.wr_en       (txfifo_wr),
		.din         (txfifo_wr_data),
		.rd_en       (txq_rd_en),
		.dout        (txq_rd_data),
		.empty       (txq_empty),
		.full        (),
		.nearly_full (txfifo_nearly_full)
	);

	// card to host, fsm pops from the head
	sync_fifo #(
		.WIDTH      (RXQ_WIDTH),
		.DEPTH_LOG2 (RXQ_DEPTH_LOG2),
		.SHOW_AHEAD (1'b1)
	) rx_queue (
		.cpci_clk    (cpci_clk),
		.cpci_reset  (cpci_reset),
		.srst        (1'b0),
		.wr_en       (rxq_wr_en),
		.din         (rxq_wr_data),
		.rd_en       (rxfifo_rd_inc),
		.dout        (rxfifo_rd_data),
		.empty       (rxfifo_empty),
		.full        (rxq_full),
		.nearly_full ()
	);

endmodule

/* source/dma_pkg.sv */
//////////////////////////////
// cpci dma shared definitions
//////////////////////////////
package dma_pkg;

	// bus and counter widths
	localparam int DMA_DATA_WIDTH    = 32;
	localparam int NUM_CPU_QUEUES    = 4;
	localparam int PKT_LEN_CNT_WIDTH = 11;
	localparam int PKT_LEN_THRESHOLD = (1 << PKT_LEN_CNT_WIDTH) - 1 - 4;

	// op codes, request and ack
	localparam logic [1:0] OP_CODE_IDLE         = 2'd0;
	localparam logic [1:0] OP_CODE_STATUS_QUERY = 2'd1;
	localparam logic [1:0] OP_CODE_TRANSF_C2N   = 2'd2;
	localparam logic [1:0] OP_CODE_TRANSF_N2C   = 2'd3;

	// rx queue word is {eop, bytecnt, data}, bytecnt 0 means 4 bytes
	localparam int RXQ_WIDTH    = DMA_DATA_WIDTH + 3;
	localparam int RXQ_EOP_BIT  = DMA_DATA_WIDTH + 2;
	localparam int RXQ_BCNT_LSB = DMA_DATA_WIDTH;

	// tx queue word, read as packet data or as a request
	typedef union packed {
		struct packed {
			logic                      is_req;
			logic                      eop;
			logic [1:0]                valid_bytes; // 0 = all four
			logic [DMA_DATA_WIDTH-1:0] data;
		} data_view;
		struct packed {
			logic        is_req;
			logic        dir_rx;      // 1 = dma rx
			logic [1:0]  zero;
			logic [27:0] pad;
			logic [3:0]  queue_id;
		} req_view;
	} txq_word_t;

	// queue and buffer sizing
	localparam int TXQ_DEPTH_LOG2          = 4;
	localparam int RXQ_DEPTH_LOG2          = 4;
	localparam int PKT_BUF_DEPTH_LOG2      = 9;
	localparam int FIFO_NEARLY_FULL_MARGIN = 4;

	// bus fsm state encoding
	localparam logic [3:0] S_IDLE     = 4'h0;
	localparam logic [3:0] S_QUERY    = 4'h1;
	localparam logic [3:0] S_C2N_QID  = 4'h2;
	localparam logic [3:0] S_C2N_LEN  = 4'h3;
	localparam logic [3:0] S_C2N_DATA = 4'h4;
	localparam logic [3:0] S_C2N_DONE = 4'h5;
	localparam logic [3:0] S_N2C_QID  = 4'h6;
	localparam logic [3:0] S_N2C_ENQ  = 4'h7;
	localparam logic [3:0] S_N2C_LEN  = 4'h8;
	localparam logic [3:0] S_N2C_DEQ  = 4'h9;
	localparam logic [3:0] S_N2C_DONE = 4'hA;

endpackage

/* source/sync_fifo.sv */
`timescale 1ns/1ps
//////////////////////////////
// single clock fifo
//////////////////////////////
module sync_fifo #(
	parameter int WIDTH      = 32,
	parameter int DEPTH_LOG2 = 4,
	parameter bit SHOW_AHEAD = 1'b0
) (
	input  logic             cpci_clk,
	input  logic             cpci_reset,
	input  logic             srst,
	input  logic             wr_en,
	input  logic [WIDTH-1:0] din,
	input  logic             rd_en,
	output logic [WIDTH-1:0] dout,
	output logic             empty,
	output logic             full,
	output logic             nearly_full
);
	import dma_pkg::*;

	logic [WIDTH-1:0]      mem [0:(1 << DEPTH_LOG2)-1];
	logic [DEPTH_LOG2-1:0] rd_ptr, wr_ptr;
	logic [DEPTH_LOG2:0]   count;
	logic [DEPTH_LOG2:0]   free_cnt;
	logic                  do_wr, do_rd;

	assign do_wr       = wr_en && !full;  // writes into a full fifo are dropped
	assign do_rd       = rd_en && !empty;
	assign empty       = (count == '0);
	assign full        = count[DEPTH_LOG2];
	assign free_cnt    = (DEPTH_LOG2+1)'(1 << DEPTH_LOG2) - count;
	assign nearly_full = (free_cnt <= FIFO_NEARLY_FULL_MARGIN);

	always_ff @(posedge cpci_clk) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge cpci_clk) begin
		if (cpci_reset || srst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	generate
		if (SHOW_AHEAD) begin : g_show_ahead
			assign dout = mem[rd_ptr]; // head word always visible
		end else begin : g_standard
			logic [WIDTH-1:0] dout_q;
			always_ff @(posedge cpci_clk) begin
				if (do_rd)
					dout_q <= mem[rd_ptr];
			end
			assign dout = dout_q;
		end
	endgenerate

endmodule

/* include/dma_tb_checks.svh */
//////////////////////////////
// dma testbench reference and checks
//////////////////////////////
`ifndef DMA_TB_CHECKS_SVH
`define DMA_TB_CHECKS_SVH

// status word as returned on a query
function automatic logic [31:0] exp_status_word(input logic [3:0] avail, input logic [3:0] nfull);
	return {12'h000, avail, 12'h000, nfull};
endfunction

// pos 0 is the request, pos 1 the length word, then data
function automatic dma_pkg::txq_word_t exp_txq_word(input int unsigned pos,
	input int unsigned len, input logic [3:0] qid, input logic [31:0] data);
	dma_pkg::txq_word_t w;
	int unsigned        rem;
	w = '0;
	if (pos == 0) begin
		w.req_view.is_req   = 1'b1;
		w.req_view.queue_id = qid;
	end else if (pos == 1) begin
		w.data_view.data = 32'(len);
		w.data_view.eop  = (len == 0);
	end else begin
		rem                        = len - 4 * (pos - 2);
		w.data_view.data           = data;
		w.data_view.eop            = (rem <= 4);
		w.data_view.valid_bytes    = (rem <= 4) ? 2'(rem) : 2'd0;
	end
	return w;
endfunction

// byte total of a queued packet up to its eop
function automatic logic [31:0] exp_n2c_len(input logic [dma_pkg::RXQ_WIDTH-1:0] words[$]);
	logic [31:0] sum;
	logic [1:0]  bcnt;
	sum = '0;
	foreach (words[i]) begin
		bcnt = words[i][dma_pkg::RXQ_BCNT_LSB +: 2];
		sum  = sum + ((bcnt == 2'd0) ? 32'd4 : 32'(bcnt));
		if (words[i][dma_pkg::RXQ_EOP_BIT])
			break;
	end
	return sum;
endfunction

task automatic check_txq(input string test_name, input dma_pkg::txq_word_t exp_w,
	input dma_pkg::txq_word_t act_w, inout int unsigned errors);
	if (act_w !== exp_w) begin
		$display("CHECK FAILED %s txq: expected %h, actual %h", test_name, exp_w, act_w);
		errors++;
	end
endtask

task automatic check_word(input string test_name, input logic [31:0] exp_w,
	input logic [31:0] act_w, inout int unsigned errors);
	if (act_w !== exp_w) begin
		$display("CHECK FAILED %s data: expected %h, actual %h", test_name, exp_w, act_w);
		errors++;
	end
endtask

task automatic check_ack(input string test_name, input logic [1:0] exp_a,
	input logic [1:0] act_a, inout int unsigned errors);
	if (act_a !== exp_a) begin
		$display("CHECK FAILED %s ack: expected %0d, actual %0d", test_name, exp_a, act_a);
		errors++;
	end
endtask

`endif

/* tb/dma_cpci_tb.sv */
`timescale 1ns/1ps
//////////////////////////////
// cpci dma testbench
//////////////////////////////
module dma_cpci_tb;
	import dma_pkg::*;

	`include "dma_tb_checks.svh"

	localparam int NUM_TESTS       = 6;
	localparam int MAX_PKT_WORDS   = 16;
	localparam int WATCHDOG_CYCLES = (NUM_TESTS * MAX_PKT_WORDS + 50) * 20;
	localparam int ACK_LATENCY     = 3;

	logic                      cpci_clk, cpci_reset, enable_dma;
	logic [1:0]                dma_op_code_req, dma_op_code_ack;
	logic [3:0]                dma_op_queue_id;
	logic                      dma_vld_c2n, dma_vld_n2c, dma_data_tri_en;
	logic [DMA_DATA_WIDTH-1:0] dma_data_c2n, dma_data_n2c;
	logic                      dma_dest_q_nearly_full_c2n, dma_dest_q_nearly_full_n2c;
	logic [NUM_CPU_QUEUES-1:0] cpu_q_dma_pkt_avail, cpu_q_dma_nearly_full;
	logic                      txq_rd_en, txq_empty;
	txq_word_t                 txq_rd_data;
	logic                      rxq_wr_en, rxq_full;
	logic [RXQ_WIDTH-1:0]      rxq_wr_data;

	integer                    seed;
	int unsigned               errors, errors_at_start, tests_run, tests_bad, bp_run;
	string                     cur_test;
	txq_word_t                 exp_txq_q[$];
	logic [DMA_DATA_WIDTH-1:0] n2c_q[$];
	logic                      txq_hold, bp_random;

	dma_cpci_top dut_i (.*);

	initial begin
		cpci_clk = 1'b0;
		forever #5 cpci_clk = ~cpci_clk;
	end

	//////////////////////////////
	// background processes
	//////////////////////////////
	initial begin : txq_reader
		forever begin
			@(negedge cpci_clk);
			if (txq_rd_en) begin // word read at the last edge
				if (exp_txq_q.size() == 0) begin
					$display("unexpected transmit queue word %h in test %s", txq_rd_data, cur_test);
					errors++;
				end else begin
					check_txq(cur_test, exp_txq_q.pop_front(), txq_rd_data, errors);
				end
			end
			txq_rd_en = !txq_hold && (txq_empty === 1'b0) && !cpci_reset;
		end
	end

	initial begin : bp_monitor
		forever begin
			@(posedge cpci_clk);
			bp_run = dma_dest_q_nearly_full_c2n ? bp_run + 1 : 0;
		end
	end

	initial begin : bp_driver
		forever begin
			@(negedge cpci_clk);
			if (bp_random)
				dma_dest_q_nearly_full_c2n = ($random(seed) & 1) != 0;
			else
				dma_dest_q_nearly_full_c2n = 1'b0;
		end
	end

	initial begin : n2c_collector
		forever begin
			@(negedge cpci_clk);
			if (dma_vld_n2c === 1'b1) begin
				n2c_q.push_back(dma_data_n2c);
				if (bp_run > 2) begin // two words may still be in flight
					$display("n2c strobe %0d cycles into back-pressure in test %s", bp_run, cur_test);
					errors++;
				end
			end
		end
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge cpci_clk);
		$display("run did not finish within %0d cycles, test %s hung", WATCHDOG_CYCLES, cur_test);
		$display("Simulation failed");
		$finish;
	end

	//////////////////////////////
	// helpers
	//////////////////////////////
	function automatic int unsigned rand_between(input int unsigned lo, input int unsigned hi);
		int unsigned r;
		r = $random(seed);
		return lo + (r % (hi - lo + 1));
	endfunction

	task automatic start_test(input string name);
		cur_test        = name;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors != errors_at_start) begin
			tests_bad++;
			$display("test %s: %0d errors", cur_test, errors - errors_at_start);
		end else begin
			$display("test %s: ok", cur_test);
		end
	endtask

	task automatic check_level(input string sig, input logic exp_v, input logic act_v);
		if (act_v !== exp_v) begin
			$display("CHECK FAILED %s %s: expected %b, actual %b", cur_test, sig, exp_v, act_v);
			errors++;
		end
	endtask

	// hold the op code until the ack matches
	task automatic issue_op(input logic [1:0] op, input logic [3:0] qid);
		int unsigned edges;
		edges           = 0;
		dma_op_code_req = op;
		dma_op_queue_id = qid;
		do begin
			@(negedge cpci_clk);
			edges++;
		end while (edges < 20 && dma_op_code_ack !== op);
		check_ack(cur_test, op, dma_op_code_ack, errors);
		if (dma_op_code_ack === op && edges != ACK_LATENCY) begin
			$display("CHECK FAILED %s ack latency: expected %0d, actual %0d", cur_test,
				ACK_LATENCY, edges);
			errors++;
		end
		dma_op_code_req = OP_CODE_IDLE;
	endtask

	task automatic run_query();
		logic [3:0] avail, nfull;
		avail                 = 4'(rand_between(0, 15));
		nfull                 = 4'(rand_between(0, 15));
		cpu_q_dma_pkt_avail   = avail;
		cpu_q_dma_nearly_full = nfull;
		issue_op(OP_CODE_STATUS_QUERY, 4'h0);
		check_level("vld_n2c", 1'b1, dma_vld_n2c); // strobe lands with the ack
		check_level("tri_en", 1'b1, dma_data_tri_en);
		check_word(cur_test, exp_status_word(avail, nfull), dma_data_n2c, errors);
	endtask

	task automatic run_c2n(input int unsigned len);
		logic [3:0]  qid;
		logic [31:0] words[$];
		int unsigned nw, k;
		qid = 4'(rand_between(0, 15));
		nw  = (len + 3) / 4;
		exp_txq_q.push_back(exp_txq_word(0, len, qid, '0));
		exp_txq_q.push_back(exp_txq_word(1, len, qid, '0));
		for (k = 0; k < nw; k++) begin
			words.push_back($random(seed));
			exp_txq_q.push_back(exp_txq_word(k + 2, len, qid, words[k]));
		end
		issue_op(OP_CODE_TRANSF_C2N, qid);
		dma_vld_c2n  = 1'b1;
		dma_data_c2n = 32'(len);
		@(negedge cpci_clk);
		for (k = 0; k < nw; k++) begin
			if (rand_between(0, 3) == 0) begin
				dma_vld_c2n = 1'b0; // idle gap
				@(negedge cpci_clk);
			end
			dma_vld_c2n  = 1'b1;
			dma_data_c2n = words[k];
			@(negedge cpci_clk);
		end
		dma_vld_c2n = 1'b0;
	endtask

	task automatic wait_txq_drained();
		int unsigned cycles;
		cycles = 0;
		while (exp_txq_q.size() != 0 && cycles < 100) begin
			@(negedge cpci_clk);
			cycles++;
		end
		if (exp_txq_q.size() != 0) begin
			$display("%0d transmit queue words missing in test %s", exp_txq_q.size(), cur_test);
			errors++;
			exp_txq_q.delete();
		end
	endtask

	task automatic run_n2c(input int unsigned nwords, input logic use_bp);
		logic [RXQ_WIDTH-1:0] rx_words[$];
		logic [31:0]          exp_len;
		logic [3:0]           qid;
		logic                 eop;
		logic [1:0]           bcnt;
		txq_word_t            req_w;
		int unsigned          k, cycles, exp_cnt;
		qid = 4'(rand_between(0, 15));
		for (k = 0; k < nwords; k++) begin
			eop  = (k == nwords - 1);
			bcnt = eop ? 2'(rand_between(0, 3)) : 2'd0; // only the tail is partial
			rx_words.push_back({eop, bcnt, 32'($random(seed))});
			rxq_wr_en   = 1'b1;
			rxq_wr_data = rx_words[k];
			@(negedge cpci_clk);
		end
		rxq_wr_en             = 1'b0;
		check_level("rxq_full", nwords >= (1 << RXQ_DEPTH_LOG2), rxq_full);
		exp_len               = exp_n2c_len(rx_words);
		exp_cnt               = 1 + (exp_len + 3) / 4; // length word plus data
		req_w                 = exp_txq_word(0, 0, qid, '0);
		req_w.req_view.dir_rx = 1'b1;
		exp_txq_q.push_back(req_w);
		n2c_q.delete();
		bp_random = use_bp;
		issue_op(OP_CODE_TRANSF_N2C, qid);
		cycles = 0;
		while (n2c_q.size() < exp_cnt && cycles < 300) begin
			@(negedge cpci_clk);
			cycles++;
		end
		bp_random = 1'b0;
		repeat (4) @(negedge cpci_clk); // catch extra strobes
		if (n2c_q.size() != exp_cnt) begin
			$display("test %s got %0d n2c words where %0d were due", cur_test, n2c_q.size(),
				exp_cnt);
			errors++;
		end else begin
			check_word(cur_test, exp_len, n2c_q[0], errors);
			for (k = 1; k < exp_cnt; k++)
				check_word(cur_test, rx_words[k-1][DMA_DATA_WIDTH-1:0], n2c_q[k], errors);
		end
	endtask

	//////////////////////////////
	// test sequence
	//////////////////////////////
	initial begin : main
		int unsigned cycles;
		seed                       = 32'h8a3;
		errors                     = 0;
		errors_at_start            = 0;
		tests_run                  = 0;
		tests_bad                  = 0;
		bp_run                     = 0;
		cur_test                   = "reset";
		txq_hold                   = 1'b0;
		bp_random                  = 1'b0;
		cpci_reset                 = 1'b1;
		enable_dma                 = 1'b0;
		dma_op_code_req            = OP_CODE_IDLE;
		dma_op_queue_id            = 4'h0;
		dma_vld_c2n                = 1'b0;
		dma_data_c2n               = '0;
		dma_dest_q_nearly_full_c2n = 1'b0;
		cpu_q_dma_pkt_avail        = '0;
		cpu_q_dma_nearly_full      = '0;
		txq_rd_en                  = 1'b0;
		rxq_wr_en                  = 1'b0;
		rxq_wr_data                = '0;
		repeat (2) @(negedge cpci_clk);
		cpci_reset = 1'b0;

		start_test("reset_idle");
		@(negedge cpci_clk);
		check_ack(cur_test, OP_CODE_IDLE, dma_op_code_ack, errors);
		check_level("vld_n2c", 1'b0, dma_vld_n2c);
		check_level("tri_en", 1'b0, dma_data_tri_en);
		check_level("nearly_full_n2c", 1'b0, dma_dest_q_nearly_full_n2c);
		check_level("txq_empty", 1'b1, txq_empty);
		check_level("rxq_full", 1'b0, rxq_full);
		dma_op_code_req = OP_CODE_STATUS_QUERY; // engine still disabled
		repeat (8) begin
			@(negedge cpci_clk);
			check_ack(cur_test, OP_CODE_IDLE, dma_op_code_ack, errors);
		end
		dma_op_code_req = OP_CODE_IDLE;
		repeat (2) @(negedge cpci_clk);
		enable_dma = 1'b1;
		end_test();

		start_test("status_query");
		run_query();
		end_test();

		start_test("c2n_packet");
		run_c2n(rand_between(1, 40));
		wait_txq_drained();
		run_query();
		run_c2n(0);
		wait_txq_drained();
		end_test();

		start_test("n2c_packet");
		run_n2c(rand_between(1, MAX_PKT_WORDS), 1'b0);
		wait_txq_drained();
		end_test();

		start_test("n2c_backpressure");
		run_query();
		run_n2c(rand_between(1, MAX_PKT_WORDS), 1'b1);
		wait_txq_drained();
		end_test();

		start_test("back_to_back");
		run_query();
		run_c2n(rand_between(1, 40));
		run_n2c(MAX_PKT_WORDS, 1'b0); // fills the receive queue
		run_query();
		wait_txq_drained();
		txq_hold = 1'b1;
		run_c2n(40); // twelve words, leaves four free
		cycles = 0;
		while (dma_dest_q_nearly_full_n2c !== 1'b1 && cycles < 10) begin
			@(negedge cpci_clk);
			cycles++;
		end
		if (dma_dest_q_nearly_full_n2c !== 1'b1) begin
			$display("nearly-full toward the cpci stayed low with the transmit queue filled");
			errors++;
		end
		txq_hold = 1'b0;
		wait_txq_drained();
		end_test();

		$display("tests run %0d, tests with errors %0d, total errors %0d", tests_run, tests_bad,
			errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
